/* compile.f */
+incdir+verilog
verilog/mips_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/avalon_if.sv
verilog/mips_alu.sv
verilog/register_file.sv
verilog/mips_cpu.sv
verilog/avalon_ram.sv
verilog/mips_system.sv
test/mips_system_chk.sv
test/mips_system_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mips_system_tb -f compile.f \
    -o sim_mips_system \
    && ./obj_dir/sim_mips_system > sim.log 2>&1 \
    || echo "build or simulation reported an error"
cat sim.log 2>/dev/null
grep -q "^\*\*\* TEST PASSED \*\*\*$" sim.log && exit 0 || exit 1

/* test/mips_system_tb.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_system_tb;

    localparam logic [4:0] r_v0 = 5'd2;
    localparam logic [4:0] r_v1 = 5'd3;
    localparam logic [4:0] r_t0 = 5'd8;
    localparam logic [4:0] r_t1 = 5'd9;
    localparam logic [4:0] r_t2 = 5'd10;
    localparam logic [4:0] r_t3 = 5'd11;
    localparam logic [4:0] r_t4 = 5'd12;
    localparam logic [4:0] r_t5 = 5'd13;
    localparam logic [4:0] r_ra = 5'd31;

    logic                clk;
    logic                reset;
    logic                active;
    mips_isa_pkg::word_t register_v0;
    logic                inst_input;
    logic [7:0]          inst_addr;
    mips_isa_pkg::word_t instruction;

    mips_isa_pkg::word_t prog [$];   // program image loaded from the reset vector up
    int errors;
    int tests_run;
    int tests_failed;

    mips_system dut (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .inst_input(inst_input),
        .inst_addr(inst_addr),
        .instruction(instruction)
    );

    bind mips_cpu mips_system_chk u_chk (
        .clk(clk),
        .reset(reset),
        .active(active),
        .read(bus.read),
        .write(bus.write),
        .address(bus.address),
        .writedata(bus.writedata),
        .byteenable(bus.byteenable),
        .waitrequest(bus.waitrequest)
    );

    always #10 clk = ~clk;   // 20 ns period

    function automatic mips_isa_pkg::word_t rtype_word(mips_isa_pkg::funct_e fn,
            logic [4:0] rd, logic [4:0] rs, logic [4:0] rt);
        mips_isa_pkg::instr_t w;
        w.opcode = mips_isa_pkg::OP_SPECIAL;
        w.rs     = rs;
        w.rt     = rt;
        w.rd     = rd;
        w.shamt  = 5'd0;
        w.funct  = fn;
        return w;
    endfunction

    function automatic mips_isa_pkg::word_t itype_word(mips_isa_pkg::opcode_e op,
            logic [4:0] rt, logic [4:0] rs, logic [15:0] imm);
        mips_isa_pkg::instr_t w;
        w.opcode                = op;
        w.rs                    = rs;
        w.rt                    = rt;
        {w.rd, w.shamt, w.funct} = imm;   // immediate overlays the low half
        return w;
    endfunction

    function automatic mips_isa_pkg::word_t halt_word();
        return rtype_word(mips_isa_pkg::FN_JR, 5'd0, 5'd0, 5'd0);   // jr $0
    endfunction

    // expected branch outcome without delay slots
    function automatic logic branch_taken(mips_isa_pkg::instr_t br, mips_isa_pkg::word_t rs_val,
            mips_isa_pkg::word_t rt_val);
        logic taken;
        taken = 1'b0;
        case (br.opcode)
            mips_isa_pkg::OP_BEQ: taken = (rs_val == rt_val);
            mips_isa_pkg::OP_BNE: taken = (rs_val != rt_val);
            mips_isa_pkg::OP_REGIMM: begin
                if (br.rt == mips_isa_pkg::RI_BLTZ || br.rt == mips_isa_pkg::RI_BLTZAL) begin
                    taken = rs_val[31];
                end else begin
                    taken = !rs_val[31];   // zero counts as >= 0
                end
            end
            default: taken = 1'b0;
        endcase
        return taken;
    endfunction

    task automatic check_word(input string name, input mips_isa_pkg::word_t got,
            input mips_isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_active(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // writes prog while reset is held and releases reset afterwards
    task automatic load_program();
        @(posedge clk);
        #1;
        reset = 1'b1;
        if (prog.size() >= `MIPS_RAM_WORDS) begin
            $display("Error at %0t ns: program of %0d words does not fit in RAM",
                     $time, prog.size());
            errors++;
        end
        foreach (prog[i]) begin
            @(posedge clk);
            #1;
            inst_input  = 1'b1;
            inst_addr   = 8'(`MIPS_RESET_VECTOR + 4 * i);
            instruction = prog[i];
        end
        @(posedge clk);
        #1;
        inst_input = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic run_program();
        int cycles;
        cycles = 0;
        while (active === 1'b1 && cycles < 2000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (active === 1'b1) begin
            $display("Error at %0t ns: program did not halt within 2000 cycles", $time);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d error(s)", name, errors - errors_before);
        end
    endtask

    task automatic halt_on_jr_zero();
        int e0;
        e0 = errors;
        prog.delete();
        prog.push_back(halt_word());
        load_program();
        check_active("active", active, 1'b1);   // one ns after reset falls
        run_program();
        check_active("active", active, 1'b0);
        check_word("register_v0", register_v0, 32'h0);
        report_test("halt_on_jr_zero", e0);
    endtask

    task automatic alu_sequence();
        logic [15:0]         imm_a;
        logic [15:0]         imm_b;
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        mips_isa_pkg::word_t sum;
        mips_isa_pkg::word_t diff;
        mips_isa_pkg::word_t both;
        mips_isa_pkg::word_t either;
        mips_isa_pkg::word_t less;
        int                  e0;
        e0     = errors;
        imm_a  = 16'h1234;
        imm_b  = 16'hFFF0;
        a      = {{16{imm_a[15]}}, imm_a};
        b      = {{16{imm_b[15]}}, imm_b};
        sum    = a + b;
        diff   = a - b;
        both   = sum & diff;
        either = b | both;
        less   = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
        prog.delete();
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_t0, 5'd0, imm_a));
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_t1, 5'd0, imm_b));
        prog.push_back(rtype_word(mips_isa_pkg::FN_ADDU, r_v1, r_t0, r_t1));
        prog.push_back(rtype_word(mips_isa_pkg::FN_SUBU, r_t2, r_t0, r_t1));
        prog.push_back(rtype_word(mips_isa_pkg::FN_AND, r_t3, r_v1, r_t2));
        prog.push_back(rtype_word(mips_isa_pkg::FN_OR, r_t4, r_t1, r_t3));
        prog.push_back(rtype_word(mips_isa_pkg::FN_SLT, r_t5, r_t1, r_t0));
        prog.push_back(rtype_word(mips_isa_pkg::FN_ADDU, r_v0, r_t4, r_t5));
        prog.push_back(halt_word());
        load_program();
        run_program();
        check_word("register_v0", register_v0, either + less);
        report_test("alu_sequence", e0);
    endtask

    task automatic bgezal_link();
        mips_isa_pkg::word_t link;
        int                  e0;
        e0 = errors;
        // v1 = -5 so the branch falls through and all three adds run
        prog.delete();
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_v0, 5'd0, 16'h0010));
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_v1, 5'd0, 16'hFFFB));
        prog.push_back(itype_word(mips_isa_pkg::OP_REGIMM, mips_isa_pkg::RI_BGEZAL, r_v1, 16'd2));
        repeat (3) prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_v0, r_v0, 16'h0030));
        prog.push_back(halt_word());
        load_program();
        run_program();
        check_word("register_v0", register_v0, 32'h10 + 3 * 32'h30);
        // taken on $0 so the subroutine returns through $31 and the link is added in
        link = `MIPS_RESET_VECTOR + 32'd8;   // bgezal sits in the second word
        prog.delete();
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_v0, 5'd0, 16'h0001));
        prog.push_back(itype_word(mips_isa_pkg::OP_REGIMM, mips_isa_pkg::RI_BGEZAL, 5'd0, 16'd2));
        prog.push_back(rtype_word(mips_isa_pkg::FN_ADDU, r_v0, r_v0, r_ra));
        prog.push_back(halt_word());
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_v0, r_v0, 16'h0100));
        prog.push_back(rtype_word(mips_isa_pkg::FN_JR, 5'd0, r_ra, 5'd0));
        load_program();
        run_program();
        check_word("register_v0", register_v0, 32'h1 + 32'h100 + link);
        report_test("bgezal_link", e0);
    endtask

    // taken path skips the +1 add
    task automatic branch_program(input mips_isa_pkg::word_t br, input logic [15:0] rs_imm,
            input logic [15:0] rt_imm);
        mips_isa_pkg::word_t rs_val;
        mips_isa_pkg::word_t rt_val;
        mips_isa_pkg::word_t expected;
        rs_val   = {{16{rs_imm[15]}}, rs_imm};
        rt_val   = {{16{rt_imm[15]}}, rt_imm};
        expected = branch_taken(mips_isa_pkg::instr_t'(br), rs_val, rt_val) ? 32'h10 : 32'h11;
        prog.delete();
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_t0, 5'd0, rs_imm));
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_t1, 5'd0, rt_imm));
        prog.push_back(br);
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_v0, r_v0, 16'h0001));
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_v0, r_v0, 16'h0010));
        prog.push_back(halt_word());
        load_program();
        run_program();
        check_word("register_v0", register_v0, expected);
    endtask

    task automatic branch_pairs();
        mips_isa_pkg::word_t beq_w;
        mips_isa_pkg::word_t bne_w;
        mips_isa_pkg::word_t bgez_w;
        mips_isa_pkg::word_t bltz_w;
        int                  e0;
        e0     = errors;
        beq_w  = itype_word(mips_isa_pkg::OP_BEQ, r_t1, r_t0, 16'd1);
        bne_w  = itype_word(mips_isa_pkg::OP_BNE, r_t1, r_t0, 16'd1);
        bgez_w = itype_word(mips_isa_pkg::OP_REGIMM, mips_isa_pkg::RI_BGEZ, r_t0, 16'd1);
        bltz_w = itype_word(mips_isa_pkg::OP_REGIMM, mips_isa_pkg::RI_BLTZ, r_t0, 16'd1);
        branch_program(beq_w, 16'd5, 16'd5);
        branch_program(beq_w, 16'd5, 16'd6);
        branch_program(bne_w, 16'd5, 16'd6);
        branch_program(bne_w, 16'd5, 16'd5);
        branch_program(bgez_w, 16'd0, 16'd0);
        branch_program(bgez_w, 16'hFFFD, 16'd0);
        branch_program(bltz_w, 16'hFFFD, 16'd0);
        branch_program(bltz_w, 16'd3, 16'd0);
        report_test("branch_pairs", e0);
    endtask

    task automatic byte_store_load();
        logic [7:0]  bytes [4];
        logic [15:0] base;
        int          e0;
        e0    = errors;
        bytes = '{8'h11, 8'hA2, 8'h5C, 8'hE7};
        base  = 16'((`MIPS_RAM_WORDS - 4) * 4);   // data word near the top of RAM
        prog.delete();
        prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_t0, 5'd0, base));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_t1, 5'd0, {8'h00, bytes[i]}));
            prog.push_back(itype_word(mips_isa_pkg::OP_SB, r_t1, r_t0, 16'(i)));
        end
        prog.push_back(itype_word(mips_isa_pkg::OP_LW, r_v0, r_t0, 16'd0));
        prog.push_back(halt_word());
        load_program();
        run_program();
        check_word("register_v0", register_v0, {bytes[3], bytes[2], bytes[1], bytes[0]});
        report_test("byte_store_load", e0);
    endtask

    task automatic random_addiu_sum();
        logic [15:0]         imm;
        mips_isa_pkg::word_t expected;
        int                  e0;
        e0       = errors;
        expected = '0;
        prog.delete();
        for (int i = 0; i < 20; i++) begin
            imm      = 16'($urandom());
            expected = expected + {{16{imm[15]}}, imm};   // wraps modulo 2^32
            prog.push_back(itype_word(mips_isa_pkg::OP_ADDIU, r_v0, r_v0, imm));
        end
        prog.push_back(halt_word());
        load_program();
        run_program();
        check_word("register_v0", register_v0, expected);
        report_test("random_addiu_sum", e0);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        inst_input   = 1'b0;
        inst_addr    = '0;
        instruction  = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h75569170));
        halt_on_jr_zero();
        alu_sequence();
        bgezal_link();
        branch_pairs();
        byte_store_load();
        random_addiu_sum();
        errors = errors + dut.u_cpu.u_chk.fail_count;   // bus assertion failures
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* test/mips_system_chk.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

// Avalon master rules and halt behavior of mips_cpu
module mips_system_chk (
    input logic                clk,
    input logic                reset,
    input logic                active,
    input logic                read,
    input logic                write,
    input mips_isa_pkg::word_t address,
    input mips_isa_pkg::word_t writedata,
    input logic [3:0]          byteenable,
    input logic                waitrequest
);

    int fail_count = 0;
    int wait_cycles;

    always_ff @(posedge clk) begin
        if (reset || !(read || write) || !waitrequest) begin
            wait_cycles <= 0;
        end else begin
            wait_cycles <= wait_cycles + 1;   // stalled cycles of the current request
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            $error("read and write high together");
            fail_count++;
        end

    a_hold_request: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(byteenable)
            && $stable(read) && $stable(write))
        else begin
            $error("request changed while waitrequest was high");
            fail_count++;
        end

    a_hold_wdata: assert property (@(posedge clk) disable iff (reset)
        write && waitrequest |=> $stable(writedata))
        else begin
            $error("writedata changed while waitrequest was high");
            fail_count++;
        end

    a_write_lanes: assert property (@(posedge clk) disable iff (reset)
        write |-> byteenable != 4'b0000)
        else begin
            $error("write with no byte lane enabled");
            fail_count++;
        end

    a_idle_halted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else begin
            $error("bus request after halt");
            fail_count++;
        end

    // RAM never stalls longer than its wait-state count
    a_wait_bound: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |-> wait_cycles < `MIPS_RAM_WAIT)
        else begin
            $error("waitrequest held past the RAM wait states");
            fail_count++;
        end

endmodule

/* verilog/mips_system.sv */
`timescale 1ns/10ps

module mips_system (
    input  logic                clk,
    input  logic                reset,
    output logic                active,
    output mips_isa_pkg::word_t register_v0,
    input  logic                inst_input,
    input  logic [7:0]          inst_addr,
    input  mips_isa_pkg::word_t instruction
);

    avalon_if bus_if ();

    // processor is the only bus master
    mips_cpu u_cpu (
        .clk(clk),
        .reset(reset),
        .bus(bus_if.master),
        .active(active),
        .register_v0(register_v0)
    );

    // program and data memory, preloaded through the loader port
    avalon_ram u_ram (
        .clk(clk),
        .reset(reset),
        .bus(bus_if.slave),
        .inst_input(inst_input),
        .inst_addr(inst_addr),
        .instruction(instruction)
    );

endmodule

/* verilog/avalon_ram.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

module avalon_ram (
    input  logic                clk,
    input  logic                reset,
    avalon_if.slave             bus,
    input  logic                inst_input,
    input  logic [7:0]          inst_addr,
    input  mips_isa_pkg::word_t instruction
);

    localparam int AW  = $clog2(`MIPS_RAM_WORDS);
    localparam int WCW = $clog2(`MIPS_RAM_WAIT + 2);

    mips_isa_pkg::word_t mem [`MIPS_RAM_WORDS];

    logic [AW-1:0]  bus_word;
    logic [AW-1:0]  load_word;
    logic [WCW-1:0] wait_cnt;
    logic           request;

    assign bus_word  = bus.address[AW+1:2];   // byte address to word index
    assign load_word = inst_addr[AW+1:2];
    assign request   = bus.read || bus.write;

    // stall each request for MIPS_RAM_WAIT cycles
    assign bus.waitrequest = request && (wait_cnt != WCW'(`MIPS_RAM_WAIT));

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!request || !bus.waitrequest) begin
            wait_cnt <= '0;                 // idle, or transfer accepted this cycle
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // loader writes whole words, the bus writes per byte lane
    always_ff @(posedge clk) begin
        if (inst_input) begin
            mem[load_word] <= instruction;
        end else if (bus.write && !bus.waitrequest) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.byteenable[lane]) begin
                    mem[bus_word][8*lane +: 8] <= bus.writedata[8*lane +: 8];
                end
            end
        end
    end

    assign bus.readdata = mem[bus_word];   // combinational, sampled in the accept cycle

endmodule

/* verilog/mips_cpu.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_cpu (
    input  logic                clk,
    input  logic                reset,
    avalon_if.master            bus,
    output logic                active,
    output mips_isa_pkg::word_t register_v0
);

    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP} pc_rule_e;
    typedef enum logic [1:0] {B_REG, B_IMM, B_LINK} b_sel_e;

    cpu_ctrl_pkg::cpu_state_e state;
    mips_isa_pkg::instr_t     ir;
    mips_isa_pkg::word_t      pc;
    mips_isa_pkg::word_t      mdr;         // load data
    mips_isa_pkg::word_t      a_q;         // rs operand
    mips_isa_pkg::word_t      b_q;         // rt operand
    mips_isa_pkg::word_t      alu_q;
    mips_isa_pkg::word_t      next_pc_q;

    cpu_ctrl_pkg::alu_op_e alu_op;
    b_sel_e                b_sel;
    pc_rule_e              pc_rule;
    logic                  wb_en;
    logic [4:0]            wb_dst;
    logic                  is_load;
    logic                  is_store;

    mips_isa_pkg::word_t imm_sext;
    mips_isa_pkg::word_t pc_plus4;
    mips_isa_pkg::word_t branch_target;
    mips_isa_pkg::word_t jump_target;
    mips_isa_pkg::word_t next_pc;
    mips_isa_pkg::word_t alu_b;
    mips_isa_pkg::word_t alu_result;
    mips_isa_pkg::word_t rs_data;
    mips_isa_pkg::word_t rt_data;
    mips_isa_pkg::word_t wr_data;
    logic                alu_zero;
    logic                alu_negative;
    logic                rf_wr_en;

    assign imm_sext      = {{16{ir[15]}}, ir[15:0]};
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};   // no delay slot
    assign jump_target   = (ir.opcode == mips_isa_pkg::OP_SPECIAL) ? a_q
                                                                   : {pc_plus4[31:28], ir[25:0], 2'b00};

    // decode, branch outcome only meaningful in EXECUTE
    always_comb begin
        alu_op   = cpu_ctrl_pkg::ALU_ADD;
        b_sel    = B_REG;
        pc_rule  = PC_SEQ;
        wb_en    = 1'b0;
        wb_dst   = ir.rt;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (ir.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                wb_dst = ir.rd;
                wb_en  = 1'b1;
                case (mips_isa_pkg::funct_e'(ir.funct))
                    mips_isa_pkg::FN_ADDU: alu_op = cpu_ctrl_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: alu_op = cpu_ctrl_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  alu_op = cpu_ctrl_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   alu_op = cpu_ctrl_pkg::ALU_OR;
                    mips_isa_pkg::FN_SLT:  alu_op = cpu_ctrl_pkg::ALU_SLT;
                    mips_isa_pkg::FN_JR: begin
                        wb_en   = 1'b0;
                        pc_rule = PC_JUMP;
                    end
                    default: wb_en = 1'b0;   // unknown funct acts as a nop
                endcase
            end
            mips_isa_pkg::OP_REGIMM: begin
                // link value goes through the ALU, linking happens even when not taken
                alu_op = cpu_ctrl_pkg::ALU_PASS_B;
                b_sel  = B_LINK;
                wb_dst = 5'd31;
                case (mips_isa_pkg::regimm_e'(ir.rt))
                    mips_isa_pkg::RI_BLTZ: pc_rule = alu_negative ? PC_BRANCH : PC_SEQ;
                    mips_isa_pkg::RI_BGEZ: pc_rule = alu_negative ? PC_SEQ : PC_BRANCH;
                    mips_isa_pkg::RI_BLTZAL: begin
                        wb_en   = 1'b1;
                        pc_rule = alu_negative ? PC_BRANCH : PC_SEQ;
                    end
                    mips_isa_pkg::RI_BGEZAL: begin
                        wb_en   = 1'b1;
                        pc_rule = alu_negative ? PC_SEQ : PC_BRANCH;
                    end
                    default: pc_rule = PC_SEQ;
                endcase
            end
            mips_isa_pkg::OP_J: pc_rule = PC_JUMP;
            mips_isa_pkg::OP_JAL: begin
                alu_op  = cpu_ctrl_pkg::ALU_PASS_B;
                b_sel   = B_LINK;
                wb_en   = 1'b1;
                wb_dst  = 5'd31;
                pc_rule = PC_JUMP;
            end
            mips_isa_pkg::OP_BEQ: pc_rule = alu_zero ? PC_BRANCH : PC_SEQ;
            mips_isa_pkg::OP_BNE: pc_rule = alu_zero ? PC_SEQ : PC_BRANCH;
            mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI: begin
                b_sel  = B_IMM;
                wb_en  = 1'b1;
                alu_op = (ir.opcode == mips_isa_pkg::OP_SLTI) ? cpu_ctrl_pkg::ALU_SLT
                                                               : cpu_ctrl_pkg::ALU_ADD;
            end
            mips_isa_pkg::OP_LW: begin
                b_sel   = B_IMM;
                wb_en   = 1'b1;
                is_load = 1'b1;
            end
            mips_isa_pkg::OP_SB: begin
                b_sel    = B_IMM;
                is_store = 1'b1;
            end
            default: wb_en = 1'b0;
        endcase
    end

    always_comb begin
        case (b_sel)
            B_IMM:   alu_b = imm_sext;
            B_LINK:  alu_b = pc_plus4;
            default: alu_b = b_q;
        endcase
        case (pc_rule)
            PC_BRANCH: next_pc = branch_target;
            PC_JUMP:   next_pc = jump_target;
            default:   next_pc = pc_plus4;
        endcase
    end

    mips_alu u_alu (
        .op(alu_op),
        .a(a_q),
        .b(alu_b),
        .result(alu_result),
        .zero(alu_zero),
        .negative(alu_negative)
    );

    assign rf_wr_en = (state == cpu_ctrl_pkg::WRITEBACK) && wb_en;
    assign wr_data  = is_load ? mdr : alu_q;

    register_file u_regs (
        .clk(clk),
        .reset(reset),
        .rs_addr(ir.rs),
        .rt_addr(ir.rt),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .wr_en(rf_wr_en),
        .wr_addr(wb_dst),
        .wr_data(wr_data),
        .v0(register_v0)
    );

    assign active = (state != cpu_ctrl_pkg::HALTED);

    // bus strobes are registered, a request is launched on the first cycle of FETCH or MEMORY
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= cpu_ctrl_pkg::FETCH;
            pc        <= `MIPS_RESET_VECTOR;
            bus.read  <= 1'b0;
            bus.write <= 1'b0;
        end else begin
            case (state)
                cpu_ctrl_pkg::FETCH: begin
                    if (!bus.read) begin
                        bus.read       <= 1'b1;
                        bus.address    <= pc;
                        bus.byteenable <= 4'b1111;
                    end else if (!bus.waitrequest) begin
                        bus.read <= 1'b0;
                        ir       <= bus.readdata;
                        state    <= cpu_ctrl_pkg::DECODE;
                    end
                end
                cpu_ctrl_pkg::DECODE: begin
                    a_q   <= rs_data;
                    b_q   <= rt_data;
                    state <= cpu_ctrl_pkg::EXECUTE;
                end
                cpu_ctrl_pkg::EXECUTE: begin
                    alu_q     <= alu_result;
                    next_pc_q <= next_pc;
                    state     <= (is_load || is_store) ? cpu_ctrl_pkg::MEMORY
                                                       : cpu_ctrl_pkg::WRITEBACK;
                end
                cpu_ctrl_pkg::MEMORY: begin
                    if (!bus.read && !bus.write) begin
                        bus.address <= alu_q;
                        if (is_store) begin
                            bus.write      <= 1'b1;
                            bus.writedata  <= {4{b_q[7:0]}};      // byte on every lane
                            bus.byteenable <= 4'b0001 << alu_q[1:0];
                        end else begin
                            bus.read       <= 1'b1;
                            bus.byteenable <= 4'b1111;
                        end
                    end else if (!bus.waitrequest) begin
                        if (bus.read) begin
                            mdr <= bus.readdata;
                        end
                        bus.read  <= 1'b0;
                        bus.write <= 1'b0;
                        state     <= cpu_ctrl_pkg::WRITEBACK;
                    end
                end
                cpu_ctrl_pkg::WRITEBACK: begin
                    pc    <= next_pc_q;
                    state <= (next_pc_q == '0) ? cpu_ctrl_pkg::HALTED : cpu_ctrl_pkg::FETCH;
                end
                cpu_ctrl_pkg::HALTED: state <= cpu_ctrl_pkg::HALTED;   // wait for reset
                default: state <= cpu_ctrl_pkg::HALTED;
            endcase
        end
    end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          rs_addr,
    input  logic [4:0]          rt_addr,
    output mips_isa_pkg::word_t rs_data,
    output mips_isa_pkg::word_t rt_data,
    input  logic                wr_en,
    input  logic [4:0]          wr_addr,
    input  mips_isa_pkg::word_t wr_data,
    output mips_isa_pkg::word_t v0
);

    mips_isa_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin   // writes to $0 are dropped
            regs[wr_addr] <= wr_data;
        end
    end

    // asynchronous read ports
    assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

    assign v0 = regs[2];   // observation tap for the top level

endmodule

/* verilog/mips_alu.sv */
`timescale 1ns/10ps

module mips_alu (
    input  cpu_ctrl_pkg::alu_op_e op,
    input  mips_isa_pkg::word_t   a,
    input  mips_isa_pkg::word_t   b,
    output mips_isa_pkg::word_t   result,
    output logic                  zero,
    output logic                  negative
);

    logic less_signed;

    assign less_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            cpu_ctrl_pkg::ALU_ADD: begin
                result = a + b;          // wraps, no overflow trap
            end
            cpu_ctrl_pkg::ALU_SUB: begin
                result = a - b;
            end
            cpu_ctrl_pkg::ALU_AND: begin
                result = a & b;
            end
            cpu_ctrl_pkg::ALU_OR: begin
                result = a | b;
            end
            cpu_ctrl_pkg::ALU_SLT: begin
                result = {31'd0, less_signed};
            end
            cpu_ctrl_pkg::ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // branch conditions look at the operands and not at result
    assign zero     = (a == b);      // BEQ / BNE
    assign negative = a[31];         // sign of rs for the REGIMM branches

endmodule

/* verilog/avalon_if.sv */
`timescale 1ns/10ps

// Avalon-MM bus between the processor and the RAM
interface avalon_if;

    mips_isa_pkg::word_t address;   // byte address
    logic                read;
    logic                write;
    mips_isa_pkg::word_t writedata;
    logic [3:0]          byteenable;
    logic                waitrequest;
    mips_isa_pkg::word_t readdata;  // valid when read is high and waitrequest low

    modport master (
        output address,
        output read,
        output write,
        output writedata,
        output byteenable,
        input  waitrequest,
        input  readdata
    );

    modport slave (
        input  address,
        input  read,
        input  write,
        input  writedata,
        input  byteenable,
        output waitrequest,
        output readdata
    );

endinterface

/* verilog/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // sequencer states, one instruction walks through them in order
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,      // LW and SB only
        WRITEBACK,
        HALTED       // entered on a next pc of 0, left only by reset
    } cpu_state_e;

    // operations of mips_alu
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,     // signed compare, result is 0 or 1
        ALU_PASS_B   // used to route the link address
    } alu_op_e;

endpackage

/* verilog/mips_isa_pkg.sv */
package mips_isa_pkg;

    typedef logic [31:0] word_t;   // data or byte address

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_LW      = 6'h23,
        OP_SB      = 6'h28
    } opcode_e;

    // funct field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } funct_e;

    // rt field of REGIMM instructions
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_e;

    // R-type view of a word
    // I-type immediate is {rd, shamt, funct}, J-type target is bits 25:0
    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

endpackage

/* verilog/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// byte address of the first instruction fetch
// word 0 stays free so that a jump to 0 can mean halt
`define MIPS_RESET_VECTOR 32'h4

// RAM depth in 32-bit words
`define MIPS_RAM_WORDS 64

// cycles of waitrequest per transfer before the RAM accepts it
`define MIPS_RAM_WAIT 1

`endif
